// File: Makefile
# Verilator build and run for the colour-memory game testbench.
TOP = memoryGameTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir

# Fails unless the pass line appears in the simulation output.
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

// File: bench/memoryGameTb.sv
// Testbench that plays scripted colour-memory levels and checks the pixel stream and digits.
`timescale 1ns/1ps

module memoryGameTb;
    import memoryGamePkg::*;

    localparam int flashCycles      = 5;
    localparam int initialSeqLength = 3;
    localparam int maxSeqLength     = 31;
    // Levels of length 3, 4 and 3 are flashed with 2*length+1 phases each.
    localparam int flashTotal = (7 + 9 + 7) * (flashCycles + 1);
    // One frame added for the wait on the game-over banner rows.
    localparam int cycleLimit = 20 * flashTotal + screenWidth * screenHeight + 2000;

    // Inclusive game-over banner bounds of the display layout.
    localparam int bannerColFirst = 24;
    localparam int bannerColLast  = 218;
    localparam int bannerRowFirst = 143;
    localparam int bannerRowLast  = 178;

    typedef enum logic [2:0] {
        actStart,
        actReplay,
        actReplayWrong,
        actDoubleKey,
        actStall
    } action_t;

    // One scenario row; score -1 means blank digits.
    typedef struct packed {
        action_t act;
        rgb565_t colour;
        int      score;
    } step_t;

    logic        clock;
    logic        resetApp;
    keyPad_t     keysLow;
    logic        pixelReady;
    logic        pixelWrite;
    rgbPixel_t   pixel;
    segPattern_t sevenSeg0;
    segPattern_t sevenSeg1;

    int          errorCount;
    int          cycleCount;
    int          expLength;
    logic [31:0] lcgState;
    keyPad_t     learned[$];

    // Active-low digits 0 to 9 with bit 0 as segment a.
    segPattern_t segTable [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
                                   7'h12, 7'h02, 7'h78, 7'h00, 7'h10};

    step_t steps [9] = '{
        '{actStart,       colourBlack, -1},
        '{actDoubleKey,   colourBlack, -1},
        '{actReplay,      colourWon,    3},
        '{actStall,       colourWon,    3},
        '{actStart,       colourBlack,  3},
        '{actDoubleKey,   colourBlack,  3},
        '{actReplayWrong, colourRed,    4},
        '{actStart,       colourIntro, -1},
        '{actStart,       colourBlack, -1}
    };

    memoryGame #(
        .flashCycles     (flashCycles),
        .initialSeqLength(initialSeqLength),
        .maxSeqLength    (maxSeqLength)
    ) memoryGame_i (
        .clock     (clock),
        .resetApp  (resetApp),
        .keysLow   (keysLow),
        .pixelReady(pixelReady),
        .pixelWrite(pixelWrite),
        .pixel     (pixel),
        .sevenSeg0 (sevenSeg0),
        .sevenSeg1 (sevenSeg1)
    );

    // 40 ns period.
    always #20 clock = ~clock;

    // Watchdog on the whole run.
    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: expected screens not reached within %0d cycles.", cycleLimit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcgNext(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Key for a game colour or zero for any other colour.
    function automatic keyPad_t colourKey(rgb565_t c);
        case (c)
            colourGreen:  return 4'b0001;
            colourRed:    return 4'b0010;
            colourBlue:   return 4'b0100;
            colourYellow: return 4'b1000;
            default:      return 4'b0000;
        endcase
    endfunction

    // Next raster position with the column stepping first and both wrapping.
    function automatic pixelPos_t stepPos(pixelPos_t p);
        pixelPos_t n;
        n = p;
        if (p.x == xPos_t'(screenWidth - 1)) begin
            n.x = '0;
            n.y = (p.y == yPos_t'(screenHeight - 1)) ? '0 : p.y + 1'b1;
        end else begin
            n.x = p.x + 1'b1;
        end
        return n;
    endfunction

    task automatic reportErr(string name, logic [31:0] expVal, logic [31:0] gotVal);
        errorCount++;
        $display("ERR %0t %s expected %h got %h", $time, name, expVal, gotVal);
    endtask

    task automatic reportFail(string what);
        errorCount++;
        $display("At %0t the %s", $time, what);
    endtask

    // Hold for 3 cycles and release for 3.
    task automatic pressKeys(keyPad_t keys);
        @(negedge clock);
        keysLow = ~keys;
        repeat (3) @(negedge clock);
        keysLow = 4'hF;
        repeat (3) @(negedge clock);
    endtask

    task automatic waitColour(rgb565_t c);
        while (pixel.data != c) begin
            @(negedge clock);
        end
    endtask

    // Player watches the stream; each run of a game colour is one entry.
    task automatic learnSequence(int expLen);
        rgb565_t prev;
        rgb565_t d;
        int      blackRun;
        prev     = colourBlack;
        blackRun = 0;
        learned.delete();
        // Black longer than any gap means the flashing is over.
        while (learned.size() == 0 || blackRun <= 3 * (flashCycles + 1)) begin
            @(negedge clock);
            d = pixel.data;
            if (d == colourBlack) begin
                blackRun++;
            end else if (colourKey(d) != '0) begin
                if (colourKey(prev) == '0) begin
                    learned.push_back(colourKey(d));
                end else if (prev != d) begin
                    reportFail("flash colour changed with no black between flashes");
                end
                blackRun = 0;
            end else if (learned.size() != 0) begin
                reportFail("screen showed a non-game colour during the sequence");
            end
            prev = d;
        end
        if (learned.size() != expLen) begin
            reportErr("flash count", expLen, learned.size());
        end
    endtask

    // Replays the learned keys; a wrong run stops after a bad second key.
    task automatic replaySequence(logic wrong);
        keyPad_t k;
        int      pick;
        int      n;
        n = wrong ? 2 : learned.size();
        for (int i = 0; i < n; i++) begin
            k = learned[i];
            if (wrong && i == 1) begin
                lcgState = lcgNext(lcgState);
                pick = int'(lcgState[31:30]);
                // A pick equal to the right key moves on to the next key.
                if (keyPad_t'(4'b0001 << pick) == k) begin
                    pick = (pick + 1) % 4;
                end
                k = keyPad_t'(4'b0001 << pick);
            end
            pressKeys(k);
        end
    endtask

    // Ten cycles of back-pressure and then the next column.
    task automatic stallDriver();
        pixelPos_t frozen;
        @(negedge clock);
        pixelReady = 1'b0;
        @(negedge clock);
        frozen = pixel.pos;
        repeat (9) begin
            @(negedge clock);
            if (pixel.pos != frozen) begin
                reportErr("pixel.pos", frozen, pixel.pos);
            end
        end
        pixelReady = 1'b1;
        // Output register lags the scan by one cycle.
        repeat (2) @(negedge clock);
        if (pixel.pos != stepPos(frozen)) begin
            reportErr("pixel.pos", stepPos(frozen), pixel.pos);
        end
    endtask

    // Banner colour inside the bounds and black around it until both were seen.
    task automatic checkBanner(rgb565_t bannerColour);
        logic    sawIn;
        logic    sawOut;
        logic    inBanner;
        rgb565_t expColour;
        sawIn  = 1'b0;
        sawOut = 1'b0;
        while (!(sawIn && sawOut)) begin
            @(negedge clock);
            inBanner = (pixel.pos.x >= bannerColFirst) && (pixel.pos.x <= bannerColLast) &&
                       (pixel.pos.y >= bannerRowFirst) && (pixel.pos.y <= bannerRowLast);
            expColour = inBanner ? bannerColour : colourBlack;
            if (pixel.data != expColour) begin
                reportErr("pixel.data", expColour, pixel.data);
                // One wrong pixel is enough.
                sawIn  = 1'b1;
                sawOut = 1'b1;
            end
            if (inBanner) begin
                sawIn = 1'b1;
            end else begin
                sawOut = 1'b1;
            end
        end
    endtask

    task automatic checkDigits(int expScore);
        segPattern_t exp0;
        segPattern_t exp1;
        exp0 = 7'h7F;
        exp1 = 7'h7F;
        if (expScore >= 0) begin
            exp0 = segTable[expScore % 10];
            exp1 = segTable[expScore / 10];
        end
        if (sevenSeg0 != exp0) begin
            reportErr("sevenSeg0", exp0, sevenSeg0);
        end
        if (sevenSeg1 != exp1) begin
            reportErr("sevenSeg1", exp1, sevenSeg1);
        end
    endtask

    initial begin
        clock      = 1'b0;
        resetApp   = 1'b1;
        keysLow    = 4'hF;
        pixelReady = 1'b1;
        errorCount = 0;
        cycleCount = 0;
        expLength  = initialSeqLength;
        lcgState   = 32'h69f0_1d06;
        repeat (3) @(posedge clock);
        @(negedge clock);
        if (pixelWrite != 1'b0) begin
            reportErr("pixelWrite", 1'b0, pixelWrite);
        end
        resetApp = 1'b0;
        @(negedge clock);
        if (pixelWrite != 1'b1) begin
            reportErr("pixelWrite", 1'b1, pixelWrite);
        end
        if (pixel.data != colourIntro) begin
            reportErr("pixel.data", colourIntro, pixel.data);
        end
        checkDigits(-1);
        for (int i = 0; i < 9; i++) begin
            case (steps[i].act)
                actStart: begin
                    pressKeys(4'b0001);
                    if (steps[i].colour == colourBlack) begin
                        learnSequence(expLength);
                    end else begin
                        waitColour(steps[i].colour);
                    end
                end
                actReplay: begin
                    replaySequence(1'b0);
                    waitColour(steps[i].colour);
                    if (expLength < maxSeqLength) begin
                        expLength++;
                    end
                end
                actReplayWrong: replaySequence(1'b1);
                actDoubleKey:   pressKeys(4'b0101);
                actStall:       stallDriver();
                default:        reportFail("scenario table holds an unknown action");
            endcase
            // Digits follow the screen by a cycle.
            @(negedge clock);
            if (steps[i].act == actReplayWrong) begin
                checkBanner(steps[i].colour);
            end else if (pixel.data != steps[i].colour) begin
                reportErr("pixel.data", steps[i].colour, pixel.data);
            end
            checkDigits(steps[i].score);
            if (steps[i].colour == colourIntro) begin
                expLength = initialSeqLength;
            end
        end
        $display("Checks finished with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: bench/memoryGame_chk.sv
// Bound assertions on the raster position and the intro screen, attached inside the game top level.
`timescale 1ns/1ps

module memoryGame_chk (
    input logic                       clock,
    input logic                       resetApp,
    input memoryGamePkg::keyPad_t     keysLow,
    input logic                       pixelReady,
    input memoryGamePkg::pixelPos_t   pos,
    input memoryGamePkg::screenCode_t screen
);
    import memoryGamePkg::*;

    logic oneKeyHeld;

    // Exactly one key down, keys are active low.
    assign oneKeyHeld = $onehot(~keysLow);

    // Position holds while the driver is busy.
    assertPosHold: assert property (@(posedge clock) disable iff (resetApp)
        !pixelReady |=> $stable(pos))
        else $error("raster position moved while pixelReady was low");

    // Column stays on the screen.
    assertColRange: assert property (@(posedge clock) disable iff (resetApp)
        pos.x <= xPos_t'(screenWidth - 1))
        else $error("raster column beyond the last column");

    // Intro is left only after the key is released.
    assertIntroHold: assert property (@(posedge clock) disable iff (resetApp)
        (screen == screenIntro && oneKeyHeld) |=> screen == screenIntro)
        else $error("intro screen changed while a key was held");

endmodule

// Watches the controller's screen and the raster scan's position where the top wires them.
bind memoryGame memoryGame_chk memoryGame_chk_i (
    .clock     (clock),
    .resetApp  (resetApp),
    .keysLow   (keysLow),
    .pixelReady(pixelReady),
    .pos       (pos),
    .screen    (screen)
);

// File: src/gameController.sv
// Game FSM: filters the keys, builds and flashes the sequence, checks the replay, keeps score.
`timescale 1ns/1ps

module gameController #(
    parameter int flashCycles      = 25_000_000,
    parameter int initialSeqLength = 3,
    parameter int maxSeqLength     = 31
) (
    input  logic                       clock,
    input  logic                       resetApp,
    input  memoryGamePkg::keyPad_t     keysLow,
    output memoryGamePkg::screenCode_t screen,
    output memoryGamePkg::score_t      score,
    output logic                       showScore
);
    import memoryGamePkg::*;

    localparam int idxWidth   = $clog2(maxSeqLength + 1);
    localparam int flashWidth = $clog2(flashCycles + 1);

    keyPad_t               keysRaw;
    keyPad_t               key;
    logic [31:0]           freeCount;
    logic [1:0]            pick;
    keyPad_t               seqSlots [maxSeqLength];
    logic [idxWidth-1:0]   seqLength;
    logic [idxWidth-1:0]   seqIndex;
    logic                  lastEntry;
    logic [flashWidth-1:0] flashCount;
    logic                  phase;
    gameState_t            state;
    gameState_t            nextState;

    // Game colour shown for a one-hot key.
    function automatic screenCode_t keyToScreen(keyPad_t k);
        case (k)
            4'b0001: return screenGreen;
            4'b0010: return screenRed;
            4'b0100: return screenBlue;
            4'b1000: return screenYellow;
            default: return screenBlack;
        endcase
    endfunction

    // Screen shown when a state is entered from key release.
    function automatic screenCode_t entryScreen(gameState_t s);
        case (s)
            stateIntro:    return screenIntro;
            stateLevelWon: return screenLevelWon;
            stateGameOver: return screenGameOver;
            default:       return screenBlack;
        endcase
    endfunction

    // Keys are active low on the board.
    assign keysRaw = ~keysLow;

    // Only a single key counts, chords read as no key.
    assign key = ((keysRaw & (keysRaw - 1'b1)) == '0) ? keysRaw : '0;

    // Random pick from the free-running counter, shifted per entry.
    assign pick = 2'(freeCount >> seqIndex);

    assign lastEntry = (seqIndex == seqLength - 1'b1);

    // Free-running cycle counter.
    always_ff @(posedge clock or posedge resetApp) begin
        if (resetApp) begin
            freeCount <= '0;
        end else begin
            freeCount <= freeCount + 1'b1;
        end
    end

    // Sequence storage, one one-hot entry per cycle in seqGen.
    always_ff @(posedge clock) begin
        if (state == stateSeqGen) begin
            seqSlots[seqIndex] <= keyPad_t'(4'b0001 << pick);
        end
    end

    always_ff @(posedge clock or posedge resetApp) begin
        if (resetApp) begin
            state      <= stateIntro;
            nextState  <= stateIntro;
            screen     <= screenIntro;
            score      <= '0;
            showScore  <= 1'b0;
            seqLength  <= idxWidth'(initialSeqLength);
            seqIndex   <= '0;
            flashCount <= '0;
            phase      <= 1'b0;
        end else begin
            case (state)
                stateIntro: begin
                    // New game.
                    seqLength <= idxWidth'(initialSeqLength);
                    seqIndex  <= '0;
                    score     <= '0;
                    showScore <= 1'b0;
                    if (key != '0) begin
                        nextState <= stateSeqGen;
                        state     <= stateKeyRelease;
                    end
                end
                stateSeqGen: begin
                    if (lastEntry) begin
                        seqIndex   <= '0;
                        flashCount <= '0;
                        phase      <= 1'b0;
                        state      <= stateMemorize;
                    end else begin
                        seqIndex <= seqIndex + 1'b1;
                    end
                end
                stateMemorize: begin
                    // Black and colour alternate, each for flashCycles+1 cycles.
                    if (flashCount == flashWidth'(flashCycles)) begin
                        flashCount <= '0;
                        if (phase) begin
                            phase    <= 1'b0;
                            screen   <= screenBlack;
                            seqIndex <= seqIndex + 1'b1;
                        end else if (seqIndex == seqLength) begin
                            // Last black gap done, screen stays black.
                            seqIndex <= '0;
                            state    <= statePlay;
                        end else begin
                            phase  <= 1'b1;
                            screen <= keyToScreen(seqSlots[seqIndex]);
                        end
                    end else begin
                        flashCount <= flashCount + 1'b1;
                    end
                end
                statePlay: begin
                    if (key != '0) begin
                        screen <= keyToScreen(key);
                        state  <= stateKeyRelease;
                        if (key == seqSlots[seqIndex]) begin
                            // Saturate at the two-digit limit.
                            if (score != 7'd99) begin
                                score <= score + 1'b1;
                            end
                            if (lastEntry) begin
                                seqIndex  <= '0;
                                nextState <= stateLevelWon;
                                if (seqLength < idxWidth'(maxSeqLength)) begin
                                    seqLength <= seqLength + 1'b1;
                                end
                            end else begin
                                seqIndex  <= seqIndex + 1'b1;
                                nextState <= statePlay;
                            end
                        end else begin
                            nextState <= stateGameOver;
                        end
                    end
                end
                stateKeyRelease: begin
                    // Wait for all keys up, then enter the remembered state.
                    if (key == '0) begin
                        state  <= nextState;
                        screen <= entryScreen(nextState);
                    end
                end
                stateLevelWon: begin
                    showScore <= 1'b1;
                    if (key != '0) begin
                        nextState <= stateSeqGen;
                        state     <= stateKeyRelease;
                    end
                end
                stateGameOver: begin
                    showScore <= 1'b1;
                    if (key != '0) begin
                        nextState <= stateIntro;
                        state     <= stateKeyRelease;
                    end
                end
                default: begin
                    state <= stateIntro;
                end
            endcase
        end
    end

endmodule

// File: src/memoryGame.sv
// Top level of the colour-memory game: sets the game parameters and wires the four blocks.
`timescale 1ns/1ps

module memoryGame #(
    parameter int flashCycles      = 25_000_000,
    parameter int initialSeqLength = 3,
    parameter int maxSeqLength     = 31
) (
    input  logic                       clock,
    input  logic                       resetApp,
    input  memoryGamePkg::keyPad_t     keysLow,
    input  logic                       pixelReady,
    output logic                       pixelWrite,
    output memoryGamePkg::rgbPixel_t   pixel,
    output memoryGamePkg::segPattern_t sevenSeg0,
    output memoryGamePkg::segPattern_t sevenSeg1
);
    import memoryGamePkg::*;

    screenCode_t screen;
    score_t      score;
    logic        showScore;
    pixelPos_t   pos;

    // Decides what is shown.
    gameController #(
        .flashCycles     (flashCycles),
        .initialSeqLength(initialSeqLength),
        .maxSeqLength    (maxSeqLength)
    ) gameController_i (
        .clock    (clock),
        .resetApp (resetApp),
        .keysLow  (keysLow),
        .screen   (screen),
        .score    (score),
        .showScore(showScore)
    );

    // Decides where the next pixel goes.
    rasterScan rasterScan_i (
        .clock     (clock),
        .resetApp  (resetApp),
        .pixelReady(pixelReady),
        .pos       (pos),
        .pixelWrite(pixelWrite)
    );

    pixelComposer pixelComposer_i (
        .clock   (clock),
        .resetApp(resetApp),
        .screen  (screen),
        .pos     (pos),
        .pixel   (pixel)
    );

    scoreDisplay scoreDisplay_i (
        .score    (score),
        .showScore(showScore),
        .sevenSeg0(sevenSeg0),
        .sevenSeg1(sevenSeg1)
    );

endmodule

// File: src/memoryGamePkg.sv
// Shared types, colour constants and banner bounds for the colour-memory game RTL.
package memoryGamePkg;

    // Raster size of the portrait display.
    localparam int screenWidth  = 240;
    localparam int screenHeight = 320;

    // Raster coordinates.
    typedef logic [7:0] xPos_t;
    typedef logic [8:0] yPos_t;

    // One raster position.
    typedef struct packed {
        xPos_t x;
        yPos_t y;
    } pixelPos_t;

    // RGB565 pixel data.
    typedef logic [15:0] rgb565_t;

    // A pixel as it goes to the display driver.
    typedef struct packed {
        pixelPos_t pos;
        rgb565_t   data;
    } rgbPixel_t;

    // Four one-hot, active-high keys.
    typedef logic [3:0] keyPad_t;

    // What the screen shows.
    // The four game colours follow key bits 0 to 3.
    typedef enum logic [2:0] {
        screenBlack,
        screenGreen,
        screenRed,
        screenBlue,
        screenYellow,
        screenIntro,
        screenLevelWon,
        screenGameOver
    } screenCode_t;

    // Game FSM states.
    typedef enum logic [2:0] {
        stateIntro,
        stateSeqGen,
        stateMemorize,
        statePlay,
        stateKeyRelease,
        stateLevelWon,
        stateGameOver
    } gameState_t;

    // Game colours.
    localparam rgb565_t colourBlack  = 16'h0000;
    localparam rgb565_t colourGreen  = 16'h4DC4;
    localparam rgb565_t colourRed    = 16'hF920;
    localparam rgb565_t colourBlue   = 16'h24F7;
    localparam rgb565_t colourYellow = 16'hFDA0;

    // Solid fills for the intro (white) and level won (cyan) screens.
    localparam rgb565_t colourIntro = 16'hFFFF;
    localparam rgb565_t colourWon   = 16'h07FF;

    // Game-over banner, bounds inclusive.
    localparam xPos_t bannerLeft   = 8'd24;
    localparam xPos_t bannerRight  = 8'd218;
    localparam yPos_t bannerTop    = 9'd143;
    localparam yPos_t bannerBottom = 9'd178;

    // Score and active-low segment pattern, bit 0 is segment a.
    typedef logic [6:0] score_t;
    typedef logic [6:0] segPattern_t;

endpackage

// File: src/pixelComposer.sv
// Pixel composer: maps the screen code and raster position to a registered RGB565 pixel.
`timescale 1ns/1ps

module pixelComposer (
    input  logic                       clock,
    input  logic                       resetApp,
    input  memoryGamePkg::screenCode_t screen,
    input  memoryGamePkg::pixelPos_t   pos,
    output memoryGamePkg::rgbPixel_t   pixel
);
    import memoryGamePkg::*;

    logic    inBanner;
    rgb565_t colour;

    // Game-over banner area.
    assign inBanner = (pos.x >= bannerLeft) && (pos.x <= bannerRight) &&
                      (pos.y >= bannerTop) && (pos.y <= bannerBottom);

    always_comb begin
        case (screen)
            screenBlack:    colour = colourBlack;
            screenGreen:    colour = colourGreen;
            screenRed:      colour = colourRed;
            screenBlue:     colour = colourBlue;
            screenYellow:   colour = colourYellow;
            screenIntro:    colour = colourIntro;
            screenLevelWon: colour = colourWon;
            // Red banner, black around it.
            screenGameOver: colour = inBanner ? colourRed : colourBlack;
            default:        colour = colourBlack;
        endcase
    end

    // Position and colour leave together, one cycle late.
    always_ff @(posedge clock or posedge resetApp) begin
        if (resetApp) begin
            pixel <= '0;
        end else begin
            pixel.pos  <= pos;
            pixel.data <= colour;
        end
    end

endmodule

// File: src/rasterScan.sv
// Raster scan: walks column and row while the display driver is ready and drives the write strobe.
`timescale 1ns/1ps

module rasterScan (
    input  logic                     clock,
    input  logic                     resetApp,
    input  logic                     pixelReady,
    output memoryGamePkg::pixelPos_t pos,
    output logic                     pixelWrite
);
    import memoryGamePkg::*;

    logic colEnd;
    logic rowEnd;

    assign colEnd = (pos.x == xPos_t'(screenWidth - 1));
    assign rowEnd = (pos.y == yPos_t'(screenHeight - 1));

    // Position advances only while the driver is ready.
    always_ff @(posedge clock or posedge resetApp) begin
        if (resetApp) begin
            pos <= '0;
        end else if (pixelReady) begin
            if (colEnd) begin
                pos.x <= '0;
                // Row steps at the end of each line.
                if (rowEnd) begin
                    pos.y <= '0;
                end else begin
                    pos.y <= pos.y + 1'b1;
                end
            end else begin
                pos.x <= pos.x + 1'b1;
            end
        end
    end

    // Write strobe is held high from the first clock after reset.
    always_ff @(posedge clock or posedge resetApp) begin
        if (resetApp) begin
            pixelWrite <= 1'b0;
        end else begin
            pixelWrite <= 1'b1;
        end
    end

endmodule

// File: src/scoreDisplay.sv
// Score display: splits the score into two decimal digits for active-low seven-segment outputs.
`timescale 1ns/1ps

module scoreDisplay (
    input  memoryGamePkg::score_t      score,
    input  logic                       showScore,
    output memoryGamePkg::segPattern_t sevenSeg0,
    output memoryGamePkg::segPattern_t sevenSeg1
);
    import memoryGamePkg::*;

    // All segments off.
    localparam segPattern_t segBlank = 7'h7F;

    logic [3:0] ones;
    logic [3:0] tens;

    // Active-low decode, bit 0 is segment a.
    function automatic segPattern_t segDecode(logic [3:0] digit);
        case (digit)
            4'd0:    return 7'h40;
            4'd1:    return 7'h79;
            4'd2:    return 7'h24;
            4'd3:    return 7'h30;
            4'd4:    return 7'h19;
            4'd5:    return 7'h12;
            4'd6:    return 7'h02;
            4'd7:    return 7'h78;
            4'd8:    return 7'h00;
            4'd9:    return 7'h10;
            default: return segBlank;
        endcase
    endfunction

    assign ones = 4'(score % 7'd10);
    assign tens = 4'(score / 7'd10);

    // Both digits blank when no score is shown.
    assign sevenSeg0 = showScore ? segDecode(ones) : segBlank;
    assign sevenSeg1 = showScore ? segDecode(tens) : segBlank;

endmodule

// File: tb.f
src/memoryGamePkg.sv
src/gameController.sv
src/rasterScan.sv
src/pixelComposer.sv
src/scoreDisplay.sv
src/memoryGame.sv
bench/memoryGame_chk.sv
bench/memoryGameTb.sv
